// File: Bender.yml
package:
  name: msx_memory_map

sources:
  - msx_slot_pkg.sv
  - slot_bus_if.sv
  - slot_config_if.sv
  - slot_config_regs.sv
  - slot_decoder.sv
  - sdram_address_map.sv
  - msx_memory_map.sv
  - target: simulation
    files:
      - tb_msx_memory_map.sv

// File: msx_memory_map.sv
`timescale 1ns/100ps
`default_nettype none

module msx_memory_map #(
	parameter msx_slot_pkg::io_port_t	PRIMARY_SLOT_PORT	= 8'hA8,
	parameter msx_slot_pkg::io_port_t	MAPPER_PORT			= 8'hFC
) (
	input	wire						clk42m,
	input	wire						ff_reset_n,
	//	Z80 bus
	input	wire						mreq_n,
	input	wire						iorq_n,
	input	wire						rd_n,
	input	wire						wr_n,
	input	wire msx_slot_pkg::cpu_addr_t	address,
	input	wire msx_slot_pkg::cpu_data_t	wdata,
	//	Register readback
	output	msx_slot_pkg::cpu_data_t	rdata,
	output	logic						rdata_en,
	//	SDRAM request
	output	msx_slot_pkg::sdram_addr_t	sdram_address,
	output	logic						sdram_rd_n,
	output	logic						sdram_wr_n
);
	msx_slot_pkg::slot_id_t		slot_id;
	logic						secondary_hit;

	slot_bus_if		u_bus ();
	slot_config_if	u_cfg ();

	// ----------------------------------------
	//	Bus into interface
	// ----------------------------------------
	assign u_bus.mreq_n		= mreq_n;
	assign u_bus.iorq_n		= iorq_n;
	assign u_bus.rd_n		= rd_n;
	assign u_bus.wr_n		= wr_n;
	assign u_bus.address	= address;
	assign u_bus.wdata		= wdata;

	// ----------------------------------------
	//	Slot, secondary and mapper registers
	// ----------------------------------------
	slot_config_regs #(
		.PRIMARY_SLOT_PORT	( PRIMARY_SLOT_PORT	),
		.MAPPER_PORT		( MAPPER_PORT		)
	) u_slot_config_regs (
		.clk42m				( clk42m			),
		.ff_reset_n			( ff_reset_n		),
		.bus				( u_bus.sink		),
		.cfg				( u_cfg.regs		),
		.secondary_hit		( secondary_hit		),
		.rdata				( rdata				),
		.rdata_en			( rdata_en			)
	);

	//	Expanded slot of the current page
	slot_decoder u_slot_decoder (
		.bus				( u_bus.sink		),
		.cfg				( u_cfg.user		),
		.slot_id			( slot_id			),
		.secondary_hit		( secondary_hit		)
	);

	// ----------------------------------------
	//	SDRAM memory map
	// ----------------------------------------
	sdram_address_map u_sdram_address_map (
		.bus				( u_bus.sink		),
		.cfg				( u_cfg.user		),
		.slot_id			( slot_id			),
		.secondary_hit		( secondary_hit		),
		.sdram_address		( sdram_address		),
		.sdram_rd_n			( sdram_rd_n		),
		.sdram_wr_n			( sdram_wr_n		)
	);

endmodule

`default_nettype wire

// File: msx_slot_pkg.sv
`default_nettype none

package msx_slot_pkg;

	// ----------------------------------------
	//	Bus widths
	// ----------------------------------------
	localparam int CPU_ADDR_W	= 16;
	localparam int CPU_DATA_W	= 8;
	localparam int IO_PORT_W	= 8;
	localparam int SDRAM_ADDR_W	= 23;
	localparam int BANK_W		= 10;			//	Upper SDRAM bits, one per 8 KB bank

	typedef logic [CPU_ADDR_W-1:0]		cpu_addr_t;
	typedef logic [CPU_DATA_W-1:0]		cpu_data_t;
	typedef logic [IO_PORT_W-1:0]		io_port_t;
	typedef logic [SDRAM_ADDR_W-1:0]	sdram_addr_t;
	typedef logic [BANK_W-1:0]			bank_t;

	// ----------------------------------------
	//	Slot and mapper registers
	// ----------------------------------------
	typedef logic [1:0]					slot_num_t;
	typedef slot_num_t [3:0]			slot_reg_t;		//	Index = page, page 0 in bits 1:0
	typedef logic [7:0]					segment_t;
	typedef segment_t [3:0]				segment_array_t;

	//	Upper bits primary slot, lower bits secondary slot
	typedef enum logic [3:0] {
		SLOT_0_0	= 4'b0000,
		SLOT_0_1	= 4'b0001,
		SLOT_0_2	= 4'b0010,
		SLOT_0_3	= 4'b0011,
		SLOT_1		= 4'b0100,
		SLOT_2		= 4'b1000,
		SLOT_3_0	= 4'b1100,
		SLOT_3_1	= 4'b1101,
		SLOT_3_2	= 4'b1110,
		SLOT_3_3	= 4'b1111
	} slot_id_t;

	localparam cpu_addr_t		SECONDARY_REG_ADDR		= 16'hFFFF;
	localparam segment_array_t	MAPPER_RESET_SEGMENTS	= { 8'd0, 8'd1, 8'd2, 8'd3 };	//	Page 3 first

	// ----------------------------------------
	//	SDRAM bank bases, appended bits zero
	// ----------------------------------------
	localparam bank_t MAIN_ROM_BASE		= 10'h010;		//	+ A14:A13
	localparam bank_t BASICN_BASE		= 10'h018;		//	+ A13
	localparam bank_t MSX_MUSIC_BASE	= 10'h01A;		//	+ A13
	localparam bank_t EXT_BASIC_BASE	= 10'h01C;		//	+ A14:A13, logo too
	localparam bank_t SUB_ROM_BASE		= 10'h020;		//	+ A13
	localparam bank_t KANJI_BASIC_BASE	= 10'h014;		//	+ A15, A13
	localparam bank_t NEXTOR_BASE		= 10'h000;		//	+ A15:A13, banks 0 to 7

endpackage

`default_nettype wire

// File: sdram_address_map.sv
`timescale 1ns/100ps
`default_nettype none

module sdram_address_map (
	slot_bus_if.sink					bus,
	slot_config_if.user					cfg,
	input	msx_slot_pkg::slot_id_t		slot_id,
	input	wire						secondary_hit,
	output	msx_slot_pkg::sdram_addr_t	sdram_address,
	output	logic						sdram_rd_n,
	output	logic						sdram_wr_n
);
	logic	[1:0]				page;
	logic						a15;
	logic						a14;
	logic						a13;
	msx_slot_pkg::bank_t		bank;
	logic						rd_ok;
	logic						wr_ok;

	assign page	= bus.address[15:14];
	assign a15	= bus.address[15];
	assign a14	= bus.address[14];
	assign a13	= bus.address[13];

	// ----------------------------------------
	//	Bank select per expanded slot
	// ----------------------------------------
	always_comb begin
		bank	= '0;
		rd_ok	= 1'b0;
		wr_ok	= 1'b0;
		case (slot_id)
			msx_slot_pkg::SLOT_3_0: begin
				//	Mapper RAM, upper half of SDRAM
				bank	= { 1'b1, cfg.segment[page], a13 };
				rd_ok	= 1'b1;
				wr_ok	= 1'b1;
			end
			msx_slot_pkg::SLOT_0_0: begin
				bank	= msx_slot_pkg::MAIN_ROM_BASE | { 8'd0, a14, a13 };
				rd_ok	= !a15;							//	Pages 0 and 1
			end
			msx_slot_pkg::SLOT_0_1: begin
				bank	= msx_slot_pkg::BASICN_BASE | { 9'd0, a13 };
				rd_ok	= (page == 2'd1);
			end
			msx_slot_pkg::SLOT_0_2: begin
				bank	= msx_slot_pkg::MSX_MUSIC_BASE | { 9'd0, a13 };
				rd_ok	= (page == 2'd1);
			end
			msx_slot_pkg::SLOT_0_3: begin
				//	Logo and extended BASIC
				bank	= msx_slot_pkg::EXT_BASIC_BASE | { 8'd0, a14, a13 };
				rd_ok	= (page == 2'd1) || (page == 2'd2);
			end
			msx_slot_pkg::SLOT_3_1: begin
				if (page == 2'd0) begin
					bank = msx_slot_pkg::SUB_ROM_BASE | { 9'd0, a13 };
				end
				else begin
					bank = msx_slot_pkg::KANJI_BASIC_BASE | { 8'd0, a15, a13 };
				end
				rd_ok	= 1'b1;							//	Sub-ROM or Kanji BASIC everywhere
			end
			msx_slot_pkg::SLOT_3_2: begin
				bank	= msx_slot_pkg::NEXTOR_BASE | { 7'd0, a15, a14, a13 };	//	Bank 0-7
				rd_ok	= (page == 2'd1) || (page == 2'd2);
			end
			default: begin
				//	Slots 1, 2, 3-3 empty
				bank	= '0;
				rd_ok	= 1'b0;
				wr_ok	= 1'b0;
			end
		endcase
	end

	// ----------------------------------------
	//	SDRAM address and strobes
	// ----------------------------------------
	assign sdram_address	= { bank, bus.address[12:0] };	//	8 KB window

	//	FFFFh register cycle never reaches SDRAM
	assign sdram_rd_n		= !( !bus.mreq_n && !bus.rd_n && rd_ok && !secondary_hit );
	assign sdram_wr_n		= !( !bus.mreq_n && !bus.wr_n && wr_ok && !secondary_hit );

endmodule

`default_nettype wire

// File: slot_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

interface slot_bus_if;

	logic						mreq_n;		//	Memory cycle
	logic						iorq_n;		//	I/O cycle
	logic						rd_n;
	logic						wr_n;
	msx_slot_pkg::cpu_addr_t	address;
	msx_slot_pkg::cpu_data_t	wdata;		//	CPU write byte

	//	Top level side
	modport source (
		output mreq_n, iorq_n, rd_n, wr_n, address, wdata
	);

	//	Register block and decoders
	modport sink (
		input mreq_n, iorq_n, rd_n, wr_n, address, wdata
	);

endinterface

`default_nettype wire

// File: slot_config_if.sv
`timescale 1ns/100ps
`default_nettype none

interface slot_config_if;

	msx_slot_pkg::slot_reg_t		primary;		//	Port A8h
	msx_slot_pkg::slot_reg_t		secondary0;		//	FFFFh in slot 0
	msx_slot_pkg::slot_reg_t		secondary3;		//	FFFFh in slot 3
	msx_slot_pkg::segment_array_t	segment;		//	Ports FCh-FFh, one per page

	// Owner of the registers
	modport regs (
		output primary, secondary0, secondary3, segment
	);

	//	Slot decoder and SDRAM map
	modport user (
		input primary, secondary0, secondary3, segment
	);

endinterface

`default_nettype wire

// File: slot_config_regs.sv
`timescale 1ns/100ps
`default_nettype none

module slot_config_regs #(
	parameter msx_slot_pkg::io_port_t	PRIMARY_SLOT_PORT	= 8'hA8,
	parameter msx_slot_pkg::io_port_t	MAPPER_PORT			= 8'hFC
) (
	input	wire						clk42m,
	input	wire						ff_reset_n,
	slot_bus_if.sink					bus,
	slot_config_if.regs					cfg,
	input	wire						secondary_hit,		//	FFFFh access, from decoder
	output	msx_slot_pkg::cpu_data_t	rdata,
	output	logic						rdata_en
);
	msx_slot_pkg::io_port_t			port;
	logic							primary_sel;
	logic							mapper_sel;
	logic							io_wr;
	logic							io_rd;
	logic							sec_wr;
	logic							sec_rd;
	logic							sec_in_slot3;
	logic							read_hit;
	msx_slot_pkg::cpu_data_t		read_byte;

	msx_slot_pkg::slot_reg_t		ff_primary;
	msx_slot_pkg::slot_reg_t		ff_secondary0;
	msx_slot_pkg::slot_reg_t		ff_secondary3;
	msx_slot_pkg::segment_array_t	ff_segment;

	// ----------------------------------------
	//	Port decode
	// ----------------------------------------
	assign port			= bus.address[7:0];
	assign primary_sel	= (port[7:2] == PRIMARY_SLOT_PORT[7:2]);	//	Group of four, A8h-ABh
	assign mapper_sel	= (port[7:2] == MAPPER_PORT[7:2]);			//	FCh-FFh
	assign io_wr		= !bus.iorq_n && !bus.wr_n;
	assign io_rd		= !bus.iorq_n && !bus.rd_n;
	assign sec_wr		= secondary_hit && !bus.wr_n;
	assign sec_rd		= secondary_hit && !bus.rd_n;

	//	Hit only comes with slot 0 or 3 in page 3, so the MSB picks the register
	assign sec_in_slot3	= ff_primary[3][1];

	// ----------------------------------------
	//	Primary slot register
	// ----------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_primary <= '0;						//	All pages in slot 0
		end
		else if (io_wr && primary_sel) begin
			ff_primary <= bus.wdata;
		end
	end

	//	Secondary registers, the one behind page 3 answers
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_secondary0 <= '0;
			ff_secondary3 <= '0;
		end
		else if (sec_wr) begin
			if (sec_in_slot3) begin
				ff_secondary3 <= bus.wdata;
			end
			else begin
				ff_secondary0 <= bus.wdata;
			end
		end
	end

	// ----------------------------------------
	//	Mapper segment registers
	// ----------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_segment <= msx_slot_pkg::MAPPER_RESET_SEGMENTS;	//	3, 2, 1, 0
		end
		else if (io_wr && mapper_sel) begin
			ff_segment[port[1:0]] <= bus.wdata;	//	Low port bits = page
		end
	end

	assign cfg.primary		= ff_primary;
	assign cfg.secondary0	= ff_secondary0;
	assign cfg.secondary3	= ff_secondary3;
	assign cfg.segment		= ff_segment;

	// ----------------------------------------
	//	Readback
	// ----------------------------------------
	always_comb begin
		read_hit	= 1'b1;
		read_byte	= '0;
		if (sec_rd) begin
			//	Secondary register reads back inverted
			read_byte = sec_in_slot3 ? ~ff_secondary3 : ~ff_secondary0;
		end
		else if (io_rd && primary_sel) begin
			read_byte = ff_primary;
		end
		else if (io_rd && mapper_sel) begin
			read_byte = ff_segment[port[1:0]];
		end
		else begin
			read_hit = 1'b0;
		end
	end

	//	Valid pulse one cycle after the sampled read
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			rdata_en <= 1'b0;
		end
		else begin
			rdata_en <= read_hit;
		end
	end

	always_ff @(posedge clk42m) begin
		if (read_hit) begin
			rdata <= read_byte;						//	Held while idle
		end
	end

endmodule

`default_nettype wire

// File: slot_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module slot_decoder (
	slot_bus_if.sink					bus,
	slot_config_if.user					cfg,
	output	msx_slot_pkg::slot_id_t		slot_id,
	output	logic						secondary_hit
);
	logic						page3_expanded;
	logic	[1:0]				page;
	msx_slot_pkg::slot_num_t	primary_slot;
	msx_slot_pkg::slot_num_t	secondary_slot;
	msx_slot_pkg::slot_num_t	sub_slot;

	// ----------------------------------------
	//	Page and slot selection
	// ----------------------------------------
	assign page				= bus.address[15:14];			//	16 KB page
	assign primary_slot		= cfg.primary[page];

	//	Slot 0 and 3 are expanded, 1 and 2 are not
	assign secondary_slot	= (primary_slot == 2'd0) ? cfg.secondary0[page] :
							  cfg.secondary3[page];

	always_comb begin
		case (primary_slot)
			2'd0,
			2'd3:		sub_slot = secondary_slot;
			default:	sub_slot = 2'd0;					//	Plain slot, no sub number
		endcase
	end

	assign slot_id			= msx_slot_pkg::slot_id_t'({ primary_slot, sub_slot });

	// ----------------------------------------
	//	FFFFh secondary register access
	// ----------------------------------------
	assign page3_expanded	= (cfg.primary[3] == 2'd0) || (cfg.primary[3] == 2'd3);

	assign secondary_hit	= !bus.mreq_n &&
							  (bus.address == msx_slot_pkg::SECONDARY_REG_ADDR) &&
							  page3_expanded;

endmodule

`default_nettype wire

// File: tb_msx_memory_map.sv
`timescale 1ns/100ps
`default_nettype none

module tb_msx_memory_map;

	localparam int			READ_TIMEOUT	= 12;		//	Cycles to wait for rdata_en

	//	Bank bases of the reference map
	localparam logic [9:0]	MAIN_ROM		= 10'h010;
	localparam logic [9:0]	BASICN			= 10'h018;
	localparam logic [9:0]	MSX_MUSIC		= 10'h01A;
	localparam logic [9:0]	EXT_BASIC		= 10'h01C;
	localparam logic [9:0]	SUB_ROM			= 10'h020;
	localparam logic [9:0]	KANJI_BASIC		= 10'h014;
	localparam logic [9:0]	NEXTOR			= 10'h000;

	logic						clk42m;
	logic						ff_reset_n;
	logic						mreq_n;
	logic						iorq_n;
	logic						rd_n;
	logic						wr_n;
	msx_slot_pkg::cpu_addr_t	address;
	msx_slot_pkg::cpu_data_t	wdata;
	msx_slot_pkg::cpu_data_t	rdata;
	logic						rdata_en;
	msx_slot_pkg::sdram_addr_t	sdram_address;
	logic						sdram_rd_n;
	logic						sdram_wr_n;
	integer						seed;
	int							errors;
	logic	[7:0]				prim_m;				//	Register model
	logic	[7:0]				sec0_m;
	logic	[7:0]				sec3_m;
	logic	[7:0]				seg_m [4];

	msx_memory_map #(
		.PRIMARY_SLOT_PORT	( 8'hA8 ),
		.MAPPER_PORT		( 8'hFC )
	) u_msx_memory_map (.*);

	always #2 clk42m = ~clk42m;							//	4 ns period

	// -- Reference map ---------------------
	//	{wr ok, rd ok, SDRAM address} for a memory cycle at a
	function automatic logic [24:0] expected_map(input msx_slot_pkg::cpu_addr_t a);
		logic	[1:0]	pg;
		logic	[1:0]	p;
		logic	[1:0]	s;
		logic	[9:0]	up;
		logic			rd_ok;
		logic			sec;
		pg	= a[15:14];
		p	= prim_m[pg*2 +: 2];
		s	= (p == 2'd0) ? sec0_m[pg*2 +: 2] : (p == 2'd3) ? sec3_m[pg*2 +: 2] : 2'd0;
		sec	= (a == 16'hFFFF) && (prim_m[7] == prim_m[6]);	//	Page 3 in slot 0 or 3
		case ({ p, s })
			4'b1100:			up = { 1'b1, seg_m[pg], a[13] };		//	Mapper RAM
			4'b0000:			up = MAIN_ROM + { a[14], a[13] };
			4'b0001:			up = BASICN + a[13];
			4'b0010:			up = MSX_MUSIC + a[13];
			4'b0011:			up = EXT_BASIC + { a[14], a[13] };
			4'b1101:			up = (pg == 2'd0) ? SUB_ROM + a[13] : KANJI_BASIC + { a[15], a[13] };
			4'b1110:			up = NEXTOR + a[15:13];
			default:			up = '0;
		endcase
		case ({ p, s })
			4'b1100, 4'b1101:	rd_ok = 1'b1;
			4'b0000:			rd_ok = !a[15];
			4'b0001, 4'b0010:	rd_ok = (pg == 2'd1);
			4'b0011, 4'b1110:	rd_ok = (pg == 2'd1) || (pg == 2'd2);
			default:			rd_ok = 1'b0;
		endcase
		return { ({ p, s } == 4'b1100) && !sec, rd_ok && !sec, up, a[12:0] };
	endfunction

	//	Random offset in a page, never the FFFFh register
	function automatic msx_slot_pkg::cpu_addr_t rand_addr(input logic [1:0] pg);
		logic	[31:0]	r;
		r = $random(seed);
		return (r[13:0] == 14'h3FFF) ? { pg, 14'h3FFE } : { pg, r[13:0] };
	endfunction

	function automatic msx_slot_pkg::cpu_data_t rand_byte();
		logic	[31:0]	r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic check_addr(input string name, input msx_slot_pkg::sdram_addr_t e, a);
		errors += (a !== e);
		if (a !== e) $display("Fail %s: expected %h, actual %h", name, e, a);
	endtask

	task automatic check_byte(input string name, input msx_slot_pkg::cpu_data_t e, a);
		errors += (a !== e);
		if (a !== e) $display("Fail %s: expected %h, actual %h", name, e, a);
	endtask

	task automatic check_strobe(input string name, input logic e, a);
		errors += (a !== e);
		if (a !== e) $display("Fail %s: expected %b, actual %b", name, e, a);
	endtask

	// -- Bus cycles ------------------------
	task automatic drive_bus(input logic m, i, r, w, input msx_slot_pkg::cpu_addr_t a,
			input msx_slot_pkg::cpu_data_t d);
		@(posedge clk42m);
		#1;												//	Clear of the edge
		mreq_n	= m;
		iorq_n	= i;
		rd_n	= r;
		wr_n	= w;
		address	= a;
		wdata	= d;
	endtask

	task automatic mem_read(input string name, input msx_slot_pkg::cpu_addr_t a);
		logic	[24:0]	exp;
		exp = expected_map(a);
		drive_bus(1'b0, 1'b1, 1'b0, 1'b1, a, 8'h00);
		#2;												//	Map is combinational
		check_strobe({ name, " rd_n" }, !exp[23], sdram_rd_n);
		check_strobe({ name, " wr_n" }, 1'b1, sdram_wr_n);
		if (exp[23]) check_addr(name, exp[22:0], sdram_address);
		drive_bus(1'b1, 1'b1, 1'b1, 1'b1, a, 8'h00);
	endtask

	task automatic mem_write(input string name, input msx_slot_pkg::cpu_addr_t a,
			input msx_slot_pkg::cpu_data_t d);
		logic	[24:0]	exp;
		exp = expected_map(a);
		drive_bus(1'b0, 1'b1, 1'b1, 1'b0, a, d);
		#2;
		check_strobe({ name, " wr_n" }, !exp[24], sdram_wr_n);
		check_strobe({ name, " rd_n" }, 1'b1, sdram_rd_n);
		if (exp[24]) check_addr(name, exp[22:0], sdram_address);
		drive_bus(1'b1, 1'b1, 1'b1, 1'b1, a, d);
		if (a == 16'hFFFF && prim_m[7] == prim_m[6]) begin	//	Secondary of page 3's slot
			if (prim_m[7]) sec3_m = d;
			else sec0_m = d;
		end
	endtask

	task automatic io_write(input msx_slot_pkg::io_port_t port, input msx_slot_pkg::cpu_data_t d);
		drive_bus(1'b1, 1'b0, 1'b1, 1'b0, { 8'h00, port }, d);
		drive_bus(1'b1, 1'b1, 1'b1, 1'b1, { 8'h00, port }, d);
		if (port[7:2] == 6'b101010) prim_m = d;			//	A8h-ABh
		if (port[7:2] == 6'b111111) seg_m[port[1:0]] = d;	//	FCh-FFh
	endtask

	//	Valid pulse expected in the cycle after the read
	task automatic await_readback(input string name, input logic want, input msx_slot_pkg::cpu_data_t e);
		int	n;
		n = 0;
		while (rdata_en !== 1'b1 && n < READ_TIMEOUT) begin
			@(posedge clk42m);
			#1;
			n++;
		end
		if (want && rdata_en !== 1'b1) begin
			errors++;
			$display("%s: no rdata_en within %0d cycles", name, READ_TIMEOUT);
		end
		else if (!want && rdata_en === 1'b1) begin
			errors++;
			$display("%s: rdata_en came from a port without a register", name);
		end
		else if (want) begin
			if (n != 0) begin							//	One cycle latency only
				errors++;
				$display("%s: rdata_en came %0d cycles late", name, n);
			end
			check_byte(name, e, rdata);
		end
	endtask

	task automatic io_read(input string name, input msx_slot_pkg::io_port_t port, input logic want,
			input msx_slot_pkg::cpu_data_t e);
		drive_bus(1'b1, 1'b0, 1'b0, 1'b1, { 8'h00, port }, 8'h00);
		drive_bus(1'b1, 1'b1, 1'b1, 1'b1, { 8'h00, port }, 8'h00);
		await_readback(name, want, e);
	endtask

	// -- Tests -----------------------------
	task automatic test_reset_map();
		mem_read("reset main ROM page 0", rand_addr(2'd0));
		mem_read("reset main ROM page 1", rand_addr(2'd1));
		mem_read("reset page 2 read", rand_addr(2'd2));
		mem_write("reset page 2 write", rand_addr(2'd2), rand_byte());
	endtask

	task automatic test_primary_slot();
		msx_slot_pkg::cpu_data_t	v;
		v = rand_byte();
		io_write(8'hA8, v);
		io_read("primary readback", 8'hA8, 1'b1, v);
		io_read("primary mirror ABh", 8'hAB, 1'b1, v);
		io_write(8'hA8, 8'h99);							//	Slots 1 and 2 only
		for (int pg = 0; pg < 4; pg++)
			mem_read("primary empty slot", rand_addr(pg[1:0]));
	endtask

	task automatic test_secondary();
		msx_slot_pkg::cpu_data_t	v;
		v = rand_byte();
		v[3:0] = 4'b0101;								//	Pages 0 and 1 in 3-1
		io_write(8'hA8, 8'hCF);							//	Page 2 in slot 0, rest slot 3
		mem_write("secondary write", 16'hFFFF, v);
		mem_read("secondary read", 16'hFFFF);
		await_readback("secondary readback", 1'b1, ~v);
		mem_read("sub-ROM page 0", rand_addr(2'd0));
		mem_read("Kanji BASIC page 1", rand_addr(2'd1));
		mem_read("secondary page 3", rand_addr(2'd3));
	endtask

	task automatic test_mapper();
		for (int i = 0; i < 4; i++)
			io_read("mapper reset readback", 8'hFC + i[7:0], 1'b1, seg_m[i]);
		for (int i = 0; i < 4; i++)
			io_write(8'hFC + i[7:0], rand_byte());
		for (int i = 0; i < 4; i++)
			io_read("mapper readback", 8'hFC + i[7:0], 1'b1, seg_m[i]);
		io_write(8'hA8, 8'hFF);
		mem_write("select 3-0", 16'hFFFF, 8'h00);		//	All pages mapper RAM
		for (int pg = 0; pg < 4; pg++) begin
			mem_read("mapper RAM read", rand_addr(pg[1:0]));
			mem_write("mapper RAM write", rand_addr(pg[1:0]), rand_byte());
		end
	endtask

	task automatic test_other_slots();
		io_write(8'hA8, 8'h00);
		for (int sub = 1; sub < 4; sub++) begin			//	0-1, 0-2, 0-3
			mem_write("select slot 0 sub", 16'hFFFF, { 4{ sub[1:0] } });
			for (int pg = 0; pg < 4; pg++)
				mem_read("expanded slot 0", rand_addr(pg[1:0]));
		end
		io_write(8'hA8, 8'hFF);
		mem_write("select 3-2", 16'hFFFF, 8'hAA);
		for (int pg = 0; pg < 4; pg++)
			mem_read("Nextor", rand_addr(pg[1:0]));
		io_read("unused port 40h", 8'h40, 1'b0, 8'h00);	//	Timeout is the pass case
	endtask

	initial begin
		seed		= 32'hcfe3;
		errors		= 0;
		clk42m		= 1'b0;
		ff_reset_n	= 1'b0;
		mreq_n		= 1'b1;
		iorq_n		= 1'b1;
		rd_n		= 1'b1;
		wr_n		= 1'b1;
		address		= '0;
		wdata		= '0;
		prim_m		= 8'h00;
		sec0_m		= 8'h00;
		sec3_m		= 8'h00;
		seg_m		= '{ 8'd3, 8'd2, 8'd1, 8'd0 };		//	Pages 0 to 3
		repeat (3) @(posedge clk42m);
		#1;
		ff_reset_n	= 1'b1;
		test_reset_map();
		test_primary_slot();
		test_secondary();
		test_mapper();
		test_other_slots();
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
msx_slot_pkg.sv
slot_bus_if.sv
slot_config_if.sv
slot_config_regs.sv
slot_decoder.sv
sdram_address_map.sv
msx_memory_map.sv
tb_msx_memory_map.sv
